// File: src.f
+incdir+rtl
rtl/bmd_rq_pkg.sv
rtl/rq_beat_if.sv
rtl/rq_write_sequencer.sv
rtl/rq_beat_formatter.sv
rtl/bmd_rq_write.sv
tests/tb_clk_gen.sv
tests/tb_bmd_rq_write.sv

// File: Bender.yml
package:
  name: bmd_rq_write

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bmd_rq_pkg.sv
      - rtl/rq_beat_if.sv
      - rtl/rq_write_sequencer.sv
      - rtl/rq_beat_formatter.sv
      - rtl/bmd_rq_write.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_bmd_rq_write.sv

// File: tests/tb_bmd_rq_write.sv
// RQ memory write generator testbench
`timescale 1ns/1ps
`default_nettype none

`include "bmd_rq_macros.svh"

module tb_bmd_rq_write;

   localparam int TOTAL_BEATS     = 16;  // Beats of all tests together
   localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20;

   typedef struct packed {
      bmd_rq_pkg::rq_data_t data;
      bmd_rq_pkg::rq_keep_t keep;
      logic                 last;
      bmd_rq_pkg::rq_be_t   fbe;
      bmd_rq_pkg::rq_be_t   lbe;
   } beat_t;

   logic                    user_clk;
   logic                    arst_n;
   logic                    init_rst;
   logic                    mwr_start;
   bmd_rq_pkg::rq_len_t     mwr_len;
   bmd_rq_pkg::rq_dw_addr_t mwr_addr;
   logic [31:0]             mwr_data;
   bmd_rq_pkg::rq_count_t   mwr_count;
   logic                    mwr_done;
   logic                    tready;
   bmd_rq_pkg::rq_data_t    tdata;
   bmd_rq_pkg::rq_keep_t    tkeep;
   logic                    tlast;
   logic                    tvalid;
   bmd_rq_pkg::rq_be_t      first_be;
   bmd_rq_pkg::rq_be_t      last_be;
   bmd_rq_pkg::rq_parity_t  parity;

   logic                    rand_ready;
   beat_t                   exp_q[$];
   int                      beats_seen;
   logic                    stalled;
   logic                    final_seen;
   logic                    done_prev;
   logic [639:0]            held_out;

   tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(4)) tb_clk_gen_i (
      .clk_o    (user_clk),
      .arst_n_o (arst_n)
   );

   bmd_rq_write #(.PARITY_EN(1'b1)) bmd_rq_write_i (
      .user_clk           (user_clk),
      .arst_n_i           (arst_n),
      .init_rst_i         (init_rst),
      .s_axis_rq_tdata_o  (tdata),
      .s_axis_rq_tkeep_o  (tkeep),
      .s_axis_rq_tlast_o  (tlast),
      .s_axis_rq_tvalid_o (tvalid),
      .rq_first_be_o      (first_be),
      .rq_last_be_o       (last_be),
      .rq_parity_o        (parity),
      .s_axis_rq_tready_i (tready),
      .mwr_start_i        (mwr_start),
      .mwr_len_i          (mwr_len),
      .mwr_addr_i         (mwr_addr),
      .mwr_data_i         (mwr_data),
      .mwr_count_i        (mwr_count),
      .mwr_done_o         (mwr_done)
   );

   task automatic check_eq(input logic [639:0] act, input logic [639:0] exp, input string what);
      if (act !== exp) begin
         $display("ERROR at %0t: %s, got %0h expected %0h", $time, what, act, exp);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   function automatic bmd_rq_pkg::rq_parity_t byte_parity(input bmd_rq_pkg::rq_data_t d);
      bmd_rq_pkg::rq_parity_t p;
      for (int b = 0; b < `BMD_RQ_PARITY_W; b++) begin
         p[b] = ~(^d[8*b +: 8]);  // Odd parity
      end
      return p;
   endfunction

   // --------------------------------------------------
   // Reference model of the beat format
   // --------------------------------------------------
   task automatic expect_command(input int len, input bmd_rq_pkg::rq_dw_addr_t base,
                                 input logic [31:0] pat, input int count);
      beat_t b;
      int    rem;
      int    take;
      for (int w = 0; w < count; w++) begin
         b    = '0;
         take = (len < `BMD_RQ_HDR_PAYLOAD_DW) ? len : `BMD_RQ_HDR_PAYLOAD_DW;
         b.data[63:2]  = {32'd0, bmd_rq_pkg::rq_dw_addr_t'(base + 30'(len * w))};
         b.data[74:64] = 11'(len);
         b.data[78:75] = 4'(`BMD_RQ_REQ_TYPE_MWR);
         for (int d = 0; d < `BMD_RQ_HDR_DW + take; d++) begin
            b.keep[d] = 1'b1;
            if (d >= `BMD_RQ_HDR_DW) b.data[32*d +: 32] = pat;
         end
         b.fbe  = 4'hF;
         b.lbe  = (len == 1) ? 4'h0 : 4'hF;
         rem    = len - take;
         b.last = (rem == 0);
         exp_q.push_back(b);
         while (rem > 0) begin  // Data beats of the same write
            b    = '0;
            take = (rem > `BMD_RQ_DW_PER_BEAT) ? `BMD_RQ_DW_PER_BEAT : rem;
            for (int d = 0; d < take; d++) begin
               b.keep[d]          = 1'b1;
               b.data[32*d +: 32] = pat;
            end
            rem    = rem - take;
            b.last = (rem == 0);
            exp_q.push_back(b);
         end
      end
   endtask

   // --------------------------------------------------
   // Stream monitor
   // --------------------------------------------------
   always @(posedge user_clk) begin
      beat_t exp;
      if (arst_n && !init_rst) begin
         if (stalled) check_eq({tdata, tkeep, tlast, tvalid, first_be, last_be, parity},
                               held_out, "outputs changed while stalled");
         if (final_seen) check_eq(mwr_done, 1'b1, "done one cycle after final beat");
         if (mwr_done && !done_prev) check_eq(exp_q.size(), 0, "done rose before last beat");
         if (tvalid && tready) begin
            if (exp_q.size() == 0) begin
               check_eq(1'b1, 1'b0, "beat transferred while none was expected");
            end else begin
               exp = exp_q.pop_front();
               check_eq(tdata, exp.data, "tdata");
               check_eq(tkeep, exp.keep, "tkeep");
               check_eq(tlast, exp.last, "tlast");
               check_eq(first_be, exp.fbe, "first byte enable");
               check_eq(last_be, exp.lbe, "last byte enable");
               check_eq(parity, byte_parity(exp.data), "byte parity");
               beats_seen++;
            end
         end
      end
      stalled    = arst_n && !init_rst && tvalid && !tready;
      final_seen = arst_n && !init_rst && tvalid && tready && (exp_q.size() == 0);
      done_prev  = mwr_done;
      held_out   = {tdata, tkeep, tlast, tvalid, first_be, last_be, parity};
   end

   // Sink ready, random during the back-pressure test
   always @(posedge user_clk) begin
      tready <= rand_ready ? 1'($urandom % 2) : 1'b1;
   end

   // --------------------------------------------------
   // Command helpers
   // --------------------------------------------------
   task automatic start_command(input int len, input bmd_rq_pkg::rq_dw_addr_t addr,
                                input logic [31:0] pat, input int count);
      @(posedge user_clk);
      mwr_start <= 1'b1;
      mwr_len   <= 11'(len);
      mwr_addr  <= addr;
      mwr_data  <= pat;
      mwr_count <= 16'(count);
      @(posedge user_clk);
      mwr_start <= 1'b0;
   endtask

   task automatic wait_done();
      while (!mwr_done) @(posedge user_clk);
      check_eq(exp_q.size(), 0, "beats still outstanding at done");
   endtask

   task automatic clear_done();
      @(posedge user_clk);
      init_rst <= 1'b1;
      @(posedge user_clk);
      init_rst <= 1'b0;
      @(posedge user_clk);
      check_eq(mwr_done, 1'b0, "done after clear");
   endtask

   task automatic run_write(input int len, input bmd_rq_pkg::rq_dw_addr_t addr,
                            input logic [31:0] pat, input int count);
      expect_command(len, addr, pat, count);
      start_command(len, addr, pat, count);
      wait_done();
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic reset_and_short_write();
      @(posedge user_clk);
      check_eq(tvalid, 1'b0, "tvalid after reset");
      check_eq(mwr_done, 1'b0, "done after reset");
      run_write(5, 30'h0000_1000, 32'hA5A5_0001, 1);
   endtask

   task automatic long_split_write();
      clear_done();
      run_write(30, 30'h0002_0040, 32'h1234_5678, 1);  // 12 + 16 + 2 dwords
   endtask

   task automatic consecutive_writes();
      clear_done();
      run_write(1, 30'h3FFF_FFFE, 32'hDEAD_BEEF, 3);  // Address wraps
   endtask

   task automatic random_back_pressure();
      clear_done();
      rand_ready <= 1'b1;
      run_write(20, 30'h0000_0100, 32'h0F0F_C3C3, 4);
      rand_ready <= 1'b0;
   endtask

   task automatic done_flag_handling();
      start_command(1, 30'h0000_0200, 32'h5555_AAAA, 1);  // Done still high
      repeat (10) @(posedge user_clk);
      check_eq(mwr_done, 1'b1, "done held before clear");
      clear_done();
      start_command(4, 30'h0000_0300, 32'h7777_0000, 0);
      repeat (10) @(posedge user_clk);
      check_eq(mwr_done, 1'b0, "done after zero count");
      run_write(2, 30'h0000_0400, 32'h2468_ACE0, 1);
   endtask

   // Hang guard
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge user_clk);
      $display("Timeout: the DUT stopped making progress before the tests ended");
      $display("CHECKS FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(32'h7474));
      init_rst   = 1'b0;
      mwr_start  = 1'b0;
      mwr_len    = '0;
      mwr_addr   = '0;
      mwr_data   = '0;
      mwr_count  = '0;
      tready     = 1'b1;
      rand_ready = 1'b0;
      beats_seen = 0;
      stalled    = 1'b0;
      final_seen = 1'b0;
      done_prev  = 1'b0;
      wait (arst_n === 1'b1);
      reset_and_short_write();
      long_split_write();
      consecutive_writes();
      random_back_pressure();
      done_flag_handling();
      check_eq(beats_seen, TOTAL_BEATS, "transferred beat count");
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS  = 100,
   parameter int RST_CYCLES = 4
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Reset released on a rising edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      arst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

// File: rtl/bmd_rq_write.sv
// PCIe DMA memory write generator
`timescale 1ns/1ps
`default_nettype none

module bmd_rq_write #(
   parameter bit PARITY_EN = 1'b0
) (
   input  wire logic                    user_clk,
   input  wire logic                    arst_n_i,
   input  wire logic                    init_rst_i,

   // Requester request stream
   output wire bmd_rq_pkg::rq_data_t    s_axis_rq_tdata_o,
   output wire bmd_rq_pkg::rq_keep_t    s_axis_rq_tkeep_o,
   output wire logic                    s_axis_rq_tlast_o,
   output wire logic                    s_axis_rq_tvalid_o,
   output wire bmd_rq_pkg::rq_be_t      rq_first_be_o,
   output wire bmd_rq_pkg::rq_be_t      rq_last_be_o,
   output wire bmd_rq_pkg::rq_parity_t  rq_parity_o,
   input  wire logic                    s_axis_rq_tready_i,

   // Command
   input  wire logic                    mwr_start_i,
   input  wire bmd_rq_pkg::rq_len_t     mwr_len_i,
   input  wire bmd_rq_pkg::rq_dw_addr_t mwr_addr_i,
   input  wire logic [31:0]             mwr_data_i,
   input  wire bmd_rq_pkg::rq_count_t   mwr_count_i,
   output wire logic                    mwr_done_o
);

   rq_beat_if beat_if ();

   rq_write_sequencer rq_write_sequencer_i (
      .user_clk    (user_clk),
      .arst_n_i    (arst_n_i),
      .init_rst_i  (init_rst_i),
      .mwr_start_i (mwr_start_i),
      .mwr_len_i   (mwr_len_i),
      .mwr_addr_i  (mwr_addr_i),
      .mwr_data_i  (mwr_data_i),
      .mwr_count_i (mwr_count_i),
      .done_i      (mwr_done_o),   // Blocks restart until cleared
      .beat_o      (beat_if.sequencer)
   );

   rq_beat_formatter #(
      .PARITY_EN (PARITY_EN)
   ) rq_beat_formatter_i (
      .user_clk           (user_clk),
      .arst_n_i           (arst_n_i),
      .init_rst_i         (init_rst_i),
      .beat_i             (beat_if.formatter),
      .s_axis_rq_tready_i (s_axis_rq_tready_i),
      .s_axis_rq_tdata_o  (s_axis_rq_tdata_o),
      .s_axis_rq_tkeep_o  (s_axis_rq_tkeep_o),
      .s_axis_rq_tlast_o  (s_axis_rq_tlast_o),
      .s_axis_rq_tvalid_o (s_axis_rq_tvalid_o),
      .rq_first_be_o      (rq_first_be_o),
      .rq_last_be_o       (rq_last_be_o),
      .rq_parity_o        (rq_parity_o),
      .mwr_done_o         (mwr_done_o)
   );

endmodule

`default_nettype wire

// File: rtl/rq_beat_formatter.sv
// RQ stream beat formatter
`timescale 1ns/1ps
`default_nettype none

`include "bmd_rq_macros.svh"

module rq_beat_formatter #(
   parameter bit PARITY_EN = 1'b0
) (
   input  wire logic              user_clk,
   input  wire logic              arst_n_i,
   input  wire logic              init_rst_i,
   rq_beat_if.formatter           beat_i,
   input  wire logic              s_axis_rq_tready_i,
   output bmd_rq_pkg::rq_data_t   s_axis_rq_tdata_o,
   output bmd_rq_pkg::rq_keep_t   s_axis_rq_tkeep_o,
   output logic                   s_axis_rq_tlast_o,
   output logic                   s_axis_rq_tvalid_o,
   output bmd_rq_pkg::rq_be_t     rq_first_be_o,
   output bmd_rq_pkg::rq_be_t     rq_last_be_o,
   output bmd_rq_pkg::rq_parity_t rq_parity_o,
   output logic                   mwr_done_o
);

   localparam int DW_N = `BMD_RQ_DW_PER_BEAT;

   logic                   load;
   logic                   final_q;   // Beat in the output register ends the command
   logic [4:0]             pl_lo;     // First payload dword
   logic [4:0]             pl_hi;     // One past the last payload dword
   bmd_rq_pkg::rq_data_t   data_d;
   bmd_rq_pkg::rq_keep_t   keep_d;
   bmd_rq_pkg::rq_be_t     first_be_d;
   bmd_rq_pkg::rq_be_t     last_be_d;
   bmd_rq_pkg::rq_parity_t par_d;

   assign beat_i.ready = !s_axis_rq_tvalid_o || s_axis_rq_tready_i;
   assign load         = beat_i.valid && beat_i.ready;

   // --------------------------------------------------
   // Beat assembly
   // --------------------------------------------------
   always_comb begin
      pl_lo  = beat_i.is_hdr ? 5'(`BMD_RQ_HDR_DW) : 5'd0;
      pl_hi  = pl_lo + beat_i.dw_cnt;
      data_d = '0;
      keep_d = '0;
      for (int i = 0; i < DW_N; i++) begin
         keep_d[i] = (i < pl_hi);
         if ((i >= pl_lo) && (i < pl_hi)) begin
            data_d[32*i +: 32] = beat_i.data;
         end
      end
      // Request header in dwords 0 to 3
      if (beat_i.is_hdr) begin
         data_d[63:2]  = {32'd0, beat_i.addr};            // Address type stays 0
         data_d[74:64] = beat_i.len;                      // Dword count
         data_d[78:75] = 4'(`BMD_RQ_REQ_TYPE_MWR);
      end
   end

   assign first_be_d = beat_i.is_hdr ? 4'hF : 4'h0;
   assign last_be_d  = (beat_i.is_hdr && (beat_i.len != 11'd1)) ? 4'hF : 4'h0;  // Single dword

   // Odd parity per byte
   for (genvar b = 0; b < `BMD_RQ_PARITY_W; b++) begin : g_parity
      assign par_d[b] = PARITY_EN ? ~(^data_d[8*b +: 8]) : 1'b0;
   end

   // --------------------------------------------------
   // Output register
   // --------------------------------------------------
   always_ff @(posedge user_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         s_axis_rq_tvalid_o <= 1'b0;
         s_axis_rq_tlast_o  <= 1'b0;
         final_q            <= 1'b0;
         mwr_done_o         <= 1'b0;
      end else if (init_rst_i) begin
         s_axis_rq_tvalid_o <= 1'b0;
         s_axis_rq_tlast_o  <= 1'b0;
         final_q            <= 1'b0;
         mwr_done_o         <= 1'b0;
      end else begin
         if (load) begin
            s_axis_rq_tvalid_o <= 1'b1;
            s_axis_rq_tlast_o  <= beat_i.eop;
            final_q            <= beat_i.final_beat;
         end else if (s_axis_rq_tready_i) begin
            s_axis_rq_tvalid_o <= 1'b0;
         end
         if (s_axis_rq_tvalid_o && s_axis_rq_tready_i && final_q) begin
            mwr_done_o <= 1'b1;  // Sticky
         end
      end
   end

   always_ff @(posedge user_clk) begin
      if (load) begin
         s_axis_rq_tdata_o <= data_d;
         s_axis_rq_tkeep_o <= keep_d;
         rq_first_be_o     <= first_be_d;
         rq_last_be_o      <= last_be_d;
         rq_parity_o       <= par_d;
      end
   end

   a_out_stable: assert property (
      @(posedge user_clk) disable iff (!arst_n_i || init_rst_i)
      s_axis_rq_tvalid_o && !s_axis_rq_tready_i |=> s_axis_rq_tvalid_o &&
         $stable({s_axis_rq_tdata_o, s_axis_rq_tkeep_o, s_axis_rq_tlast_o,
                  rq_first_be_o, rq_last_be_o, rq_parity_o}));

   // No holes in keep
   a_keep_run: assert property (
      @(posedge user_clk) disable iff (!arst_n_i || init_rst_i)
      s_axis_rq_tvalid_o |-> (s_axis_rq_tkeep_o != '0) &&
         ((s_axis_rq_tkeep_o & bmd_rq_pkg::rq_keep_t'(s_axis_rq_tkeep_o + 1'b1)) == '0));

endmodule

`default_nettype wire

// File: rtl/rq_write_sequencer.sv
// Memory write beat sequencer
`timescale 1ns/1ps
`default_nettype none

`include "bmd_rq_macros.svh"

module rq_write_sequencer (
   input  wire logic                    user_clk,
   input  wire logic                    arst_n_i,
   input  wire logic                    init_rst_i,
   input  wire logic                    mwr_start_i,
   input  wire bmd_rq_pkg::rq_len_t     mwr_len_i,
   input  wire bmd_rq_pkg::rq_dw_addr_t mwr_addr_i,
   input  wire logic [31:0]             mwr_data_i,
   input  wire bmd_rq_pkg::rq_count_t   mwr_count_i,
   input  wire logic                    done_i,
   rq_beat_if.sequencer                 beat_o
);

   bmd_rq_pkg::rq_seq_state_e state_q;
   bmd_rq_pkg::rq_count_t     count_q;
   bmd_rq_pkg::rq_count_t     w_idx_q;   // Write in progress
   bmd_rq_pkg::rq_dw_cnt_t    dw_rem_q;  // Not yet put in a descriptor

   // Latched command
   bmd_rq_pkg::rq_len_t       len_q;
   bmd_rq_pkg::rq_dw_addr_t   base_q;
   logic [31:0]               data_q;

   // Descriptor register
   logic                      valid_q;
   logic                      is_hdr_q;
   logic [4:0]                dw_cnt_q;
   bmd_rq_pkg::rq_dw_addr_t   addr_q;
   logic                      eop_q;
   logic                      final_q;

   logic                      start_ok;
   logic                      xfer;
   logic                      nxt_beat;
   logic                      load_hdr;
   logic                      load_data;
   logic                      last_wr;
   bmd_rq_pkg::rq_count_t     w_idx_nxt;
   bmd_rq_pkg::rq_len_t       h_len;
   bmd_rq_pkg::rq_dw_addr_t   h_addr;
   logic                      h_last;
   logic [4:0]                h_take;
   logic [4:0]                d_take;
   bmd_rq_pkg::rq_dw_cnt_t    h_rem;
   bmd_rq_pkg::rq_dw_cnt_t    d_rem;

   function automatic logic [4:0] take_dw(bmd_rq_pkg::rq_dw_cnt_t rem, int unsigned lim);
      if (rem > lim) begin
         return 5'(lim);
      end
      return 5'(rem);
   endfunction

   assign start_ok  = (state_q == bmd_rq_pkg::IDLE) && mwr_start_i &&
                      (mwr_count_i != '0) && !done_i;
   assign xfer      = valid_q && beat_o.ready;
   assign nxt_beat  = xfer && !final_q;
   assign load_hdr  = start_ok || (nxt_beat && (dw_rem_q == '0));
   assign load_data = nxt_beat && (dw_rem_q != '0);
   assign w_idx_nxt = w_idx_q + 1'b1;
   assign last_wr   = (w_idx_q == count_q - 1'b1);

   // --------------------------------------------------
   // Next header and data beat sizing
   // --------------------------------------------------
   always_comb begin
      if (state_q == bmd_rq_pkg::IDLE) begin  // First write straight from the command
         h_len  = mwr_len_i;
         h_addr = mwr_addr_i;
         h_last = (mwr_count_i == 16'd1);
      end else begin
         h_len  = len_q;
         h_addr = base_q + bmd_rq_pkg::rq_dw_addr_t'(len_q) *
                           bmd_rq_pkg::rq_dw_addr_t'(w_idx_nxt);
         h_last = (w_idx_nxt == count_q - 1'b1);
      end
      h_take = take_dw(bmd_rq_pkg::rq_dw_cnt_t'(h_len), `BMD_RQ_HDR_PAYLOAD_DW);
      h_rem  = bmd_rq_pkg::rq_dw_cnt_t'(h_len) - h_take;
      d_take = take_dw(dw_rem_q, `BMD_RQ_DW_PER_BEAT);
      d_rem  = dw_rem_q - d_take;
   end

   // --------------------------------------------------
   // FSM and counters
   // --------------------------------------------------
   always_ff @(posedge user_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= bmd_rq_pkg::IDLE;
         valid_q  <= 1'b0;
         count_q  <= '0;
         w_idx_q  <= '0;
         dw_rem_q <= '0;
      end else if (init_rst_i) begin
         state_q  <= bmd_rq_pkg::IDLE;
         valid_q  <= 1'b0;
         count_q  <= '0;
         w_idx_q  <= '0;
         dw_rem_q <= '0;
      end else begin
         case (state_q)
            bmd_rq_pkg::IDLE: begin
               if (start_ok) begin
                  state_q  <= bmd_rq_pkg::SEND_HDR;
                  valid_q  <= 1'b1;
                  count_q  <= mwr_count_i;
                  w_idx_q  <= '0;
                  dw_rem_q <= h_rem;
               end
            end
            bmd_rq_pkg::SEND_HDR, bmd_rq_pkg::SEND_DATA: begin
               if (xfer && final_q) begin  // Command fully handed over
                  state_q <= bmd_rq_pkg::WAIT_DONE;
                  valid_q <= 1'b0;
               end else if (load_data) begin
                  state_q  <= bmd_rq_pkg::SEND_DATA;
                  dw_rem_q <= d_rem;
               end else if (load_hdr) begin
                  state_q  <= bmd_rq_pkg::SEND_HDR;
                  w_idx_q  <= w_idx_nxt;
                  dw_rem_q <= h_rem;
               end
            end
            bmd_rq_pkg::WAIT_DONE: begin
               if (done_i) state_q <= bmd_rq_pkg::IDLE;
            end
            default: state_q <= bmd_rq_pkg::IDLE;
         endcase
      end
   end

   // Command latch and descriptor payload
   always_ff @(posedge user_clk) begin
      if (start_ok) begin
         len_q  <= mwr_len_i;
         base_q <= mwr_addr_i;
         data_q <= mwr_data_i;
      end
      if (load_hdr) begin
         is_hdr_q <= 1'b1;
         dw_cnt_q <= h_take;
         addr_q   <= h_addr;
         eop_q    <= (h_rem == '0);
         final_q  <= (h_rem == '0) && h_last;
      end else if (load_data) begin
         is_hdr_q <= 1'b0;
         dw_cnt_q <= d_take;
         eop_q    <= (d_rem == '0);
         final_q  <= (d_rem == '0) && last_wr;
      end
   end

   assign beat_o.valid      = valid_q;
   assign beat_o.is_hdr     = is_hdr_q;
   assign beat_o.dw_cnt     = dw_cnt_q;
   assign beat_o.addr       = addr_q;
   assign beat_o.len        = len_q;
   assign beat_o.data       = data_q;
   assign beat_o.eop        = eop_q;
   assign beat_o.final_beat = final_q;

   // Descriptor held until the formatter takes it
   a_desc_stable: assert property (
      @(posedge user_clk) disable iff (!arst_n_i || init_rst_i)
      beat_o.valid && !beat_o.ready |=> beat_o.valid &&
         $stable({beat_o.is_hdr, beat_o.dw_cnt, beat_o.addr, beat_o.len,
                  beat_o.data, beat_o.eop, beat_o.final_beat}));

endmodule

`default_nettype wire

// File: rtl/rq_beat_if.sv
// Beat descriptor link
`timescale 1ns/1ps
`default_nettype none

interface rq_beat_if;

   logic                    valid;
   logic                    ready;
   logic                    is_hdr;
   logic [4:0]              dw_cnt;      // Payload dwords, up to 16
   bmd_rq_pkg::rq_dw_addr_t addr;
   bmd_rq_pkg::rq_len_t     len;
   logic [31:0]             data;        // Fill pattern
   logic                    eop;         // Last beat of a write
   logic                    final_beat;  // Last beat of the command

   modport sequencer (
      output valid, is_hdr, dw_cnt, addr, len, data, eop, final_beat,
      input  ready
   );

   modport formatter (
      input  valid, is_hdr, dw_cnt, addr, len, data, eop, final_beat,
      output ready
   );

endinterface

`default_nettype wire

// File: rtl/bmd_rq_pkg.sv
// RQ write generator types
`default_nettype none

`include "bmd_rq_macros.svh"

package bmd_rq_pkg;

   // --------------------------------------------------
   // Stream beat fields
   // --------------------------------------------------
   typedef logic [`BMD_RQ_DATA_W-1:0]      rq_data_t;
   typedef logic [`BMD_RQ_DW_PER_BEAT-1:0] rq_keep_t;    // One bit per dword
   typedef logic [3:0]                     rq_be_t;
   typedef logic [`BMD_RQ_PARITY_W-1:0]    rq_parity_t;

   // --------------------------------------------------
   // Command fields
   // --------------------------------------------------
   typedef logic [10:0] rq_len_t;      // 1 to 1024 dwords
   typedef logic [29:0] rq_dw_addr_t;  // Byte address bits 31..2
   typedef logic [15:0] rq_count_t;
   typedef logic [11:0] rq_dw_cnt_t;   // Dwords left in a write

   // Sequencer FSM
   typedef enum logic [1:0] {
      IDLE,
      SEND_HDR,
      SEND_DATA,
      WAIT_DONE
   } rq_seq_state_e;

endpackage

`default_nettype wire

// File: rtl/bmd_rq_macros.svh
// RQ write generator constants
`ifndef BMD_RQ_MACROS_SVH
`define BMD_RQ_MACROS_SVH

// --------------------------------------------------
// Stream geometry
// --------------------------------------------------
`define BMD_RQ_DATA_W          512
`define BMD_RQ_DW_PER_BEAT     16
`define BMD_RQ_PARITY_W        64  // One bit per data byte

// --------------------------------------------------
// Request header
// --------------------------------------------------
`define BMD_RQ_HDR_DW          4
`define BMD_RQ_HDR_PAYLOAD_DW  12  // Dwords left over in a header beat

// Memory write request type code
`define BMD_RQ_REQ_TYPE_MWR    1

`endif
